// ==== hw/issue_pkg.sv ====
package issue_pkg;

	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] uint32_t;

	// major opcodes of the supported subset.
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_WORD    = 3'b010; // width code of LW and SW.
	localparam logic [2:0] F3_BEQ     = 3'b000;

	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_ADDI,
		OP_LW,
		OP_SW,
		OP_BEQ,
		OP_ILLEGAL
	} op_e;

	typedef struct packed {
		uint32_t pc;
		uint32_t instr;
	} fetch_entry_t;

	typedef struct packed {
		op_e       op;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		uint32_t   imm;       // already sign-extended.
		logic      uses_rs1;
		logic      uses_rs2;
		logic      writes_rd; // never set for rd zero.
		logic      is_mem;
		logic      is_branch;
		logic      is_load;
	} decoded_instr_t;

	// one result travelling down a later stage.
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		uint32_t   wdata;
	} fwd_src_t;

endpackage

// ==== hw/decode_lane_if.sv ====
interface decode_lane_if;

	issue_pkg::fetch_entry_t   entry;
	logic                      pending; // the head slot holds an instruction.
	issue_pkg::decoded_instr_t decoded;
	issue_pkg::uint32_t        op1;
	issue_pkg::uint32_t        op2;

	modport queue_mp (output entry, output pending);

	modport lane_mp (input entry, input pending, output decoded, output op1, output op2);

	modport issue_mp (input entry, input pending, input decoded, input op1, input op2);

endinterface

// ==== hw/fetch_queue.sv ====
module fetch_queue #(
	parameter int ISSUE_NUM   = 2,
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic                                     push,
	input  issue_pkg::fetch_entry_t [ISSUE_NUM-1:0]  push_entry,
	input  logic [$clog2(ISSUE_NUM+1)-1:0]           pop_num,
	output logic                                     full,
	decode_lane_if.queue_mp                          head [ISSUE_NUM]
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	issue_pkg::fetch_entry_t mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic             push_ok;

	assign full    = count > CNT_W'(QUEUE_DEPTH - ISSUE_NUM);
	assign push_ok = push && !full; // a push into a full queue is dropped.

	always_ff @(posedge clk) begin
		if (push_ok) begin
			for (int i = 0; i < ISSUE_NUM; i++) begin
				mem[wr_ptr + PTR_W'(i)] <= push_entry[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + PTR_W'(ISSUE_NUM);
			end
			rd_ptr <= rd_ptr + PTR_W'(pop_num);
			count  <= count + (push_ok ? CNT_W'(ISSUE_NUM) : '0) - CNT_W'(pop_num);
		end
	end

	// the oldest entries sit on the head slots in order.
	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_head
		assign head[i].entry   = mem[rd_ptr + PTR_W'(i)];
		assign head[i].pending = CNT_W'(i) < count;
	end

endmodule

// ==== hw/reg_file.sv ====
module reg_file #(
	parameter int ISSUE_NUM = 2
) (
	input  logic                                    clk,
	input  logic                                    reset,
	input  issue_pkg::reg_addr_t [2*ISSUE_NUM-1:0]  raddr,
	input  logic                 [ISSUE_NUM-1:0]    we,
	input  issue_pkg::reg_addr_t [ISSUE_NUM-1:0]    waddr,
	input  issue_pkg::uint32_t   [ISSUE_NUM-1:0]    wdata,
	output issue_pkg::uint32_t   [2*ISSUE_NUM-1:0]  rdata
);

	issue_pkg::uint32_t regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < 32; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int i = 0; i < ISSUE_NUM; i++) begin // later lanes override earlier ones.
				if (we[i] && waddr[i] != '0) begin
					regs[waddr[i]] <= wdata[i];
				end
			end
		end
	end

	always_comb begin
		for (int p = 0; p < 2*ISSUE_NUM; p++) begin
			rdata[p] = (raddr[p] == '0) ? '0 : regs[raddr[p]];
		end
	end

endmodule

// ==== hw/decode_lane.sv ====
module decode_lane #(
	parameter int ISSUE_NUM = 2
) (
	decode_lane_if.lane_mp                          lane,
	output issue_pkg::reg_addr_t [1:0]              raddr,
	input  issue_pkg::uint32_t   [1:0]              rdata,
	input  issue_pkg::fwd_src_t  [ISSUE_NUM-1:0]    ex_src,
	input  issue_pkg::fwd_src_t  [ISSUE_NUM-1:0]    mem_src,
	input  issue_pkg::fwd_src_t  [ISSUE_NUM-1:0]    wb_src
);

	issue_pkg::decoded_instr_t dec;
	issue_pkg::uint32_t        instr;
	issue_pkg::uint32_t [1:0]  operand;
	logic [6:0]                opcode;
	logic [2:0]                funct3;
	logic [6:0]                funct7;

	assign instr  = lane.entry.instr;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	function automatic logic fwd_hit(issue_pkg::fwd_src_t src, issue_pkg::reg_addr_t addr);
		return src.valid && src.rd == addr && addr != '0;
	endfunction

	always_comb begin
		dec     = '0;
		dec.op  = issue_pkg::OP_ILLEGAL;
		dec.rs1 = instr[19:15];
		dec.rs2 = instr[24:20];
		dec.rd  = instr[11:7];
		case (opcode)
			issue_pkg::OPC_OP: begin
				if (funct7 == issue_pkg::F7_BASE) begin
					case (funct3)
						issue_pkg::F3_ADD_SUB: dec.op = issue_pkg::OP_ADD;
						issue_pkg::F3_SLT:     dec.op = issue_pkg::OP_SLT;
						issue_pkg::F3_XOR:     dec.op = issue_pkg::OP_XOR;
						issue_pkg::F3_OR:      dec.op = issue_pkg::OP_OR;
						issue_pkg::F3_AND:     dec.op = issue_pkg::OP_AND;
						default:               dec.op = issue_pkg::OP_ILLEGAL;
					endcase
				end else if (funct7 == issue_pkg::F7_SUB && funct3 == issue_pkg::F3_ADD_SUB) begin
					dec.op = issue_pkg::OP_SUB;
				end
			end
			issue_pkg::OPC_OP_IMM: begin
				if (funct3 == issue_pkg::F3_ADD_SUB) begin
					dec.op = issue_pkg::OP_ADDI;
				end
				dec.imm = {{20{instr[31]}}, instr[31:20]};
			end
			issue_pkg::OPC_LOAD: begin
				if (funct3 == issue_pkg::F3_WORD) begin
					dec.op = issue_pkg::OP_LW;
				end
				dec.imm = {{20{instr[31]}}, instr[31:20]};
			end
			issue_pkg::OPC_STORE: begin
				if (funct3 == issue_pkg::F3_WORD) begin
					dec.op = issue_pkg::OP_SW;
				end
				dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			issue_pkg::OPC_BRANCH: begin
				if (funct3 == issue_pkg::F3_BEQ) begin
					dec.op = issue_pkg::OP_BEQ;
				end
				dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			default: dec.op = issue_pkg::OP_ILLEGAL;
		endcase

		// illegal encodings use no registers at all.
		case (dec.op)
			issue_pkg::OP_ADD, issue_pkg::OP_SUB, issue_pkg::OP_AND,
			issue_pkg::OP_OR, issue_pkg::OP_XOR, issue_pkg::OP_SLT: begin
				dec.uses_rs1  = 1'b1;
				dec.uses_rs2  = 1'b1;
				dec.writes_rd = 1'b1;
			end
			issue_pkg::OP_ADDI: begin
				dec.uses_rs1  = 1'b1;
				dec.writes_rd = 1'b1;
			end
			issue_pkg::OP_LW: begin
				dec.uses_rs1  = 1'b1;
				dec.writes_rd = 1'b1;
				dec.is_mem    = 1'b1;
				dec.is_load   = 1'b1;
			end
			issue_pkg::OP_SW: begin
				dec.uses_rs1 = 1'b1;
				dec.uses_rs2 = 1'b1;
				dec.is_mem   = 1'b1;
			end
			issue_pkg::OP_BEQ: begin
				dec.uses_rs1  = 1'b1;
				dec.uses_rs2  = 1'b1;
				dec.is_branch = 1'b1;
			end
			default: dec.uses_rs1 = 1'b0;
		endcase
		dec.writes_rd = dec.writes_rd && (dec.rd != '0);
	end

	assign raddr[0] = dec.rs1;
	assign raddr[1] = dec.rs2;

	// WB is applied first so that MEM and then EX override it.
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			operand[k] = rdata[k];
			for (int i = 0; i < ISSUE_NUM; i++) begin
				if (fwd_hit(wb_src[i], raddr[k])) operand[k] = wb_src[i].wdata;
			end
			for (int i = 0; i < ISSUE_NUM; i++) begin
				if (fwd_hit(mem_src[i], raddr[k])) operand[k] = mem_src[i].wdata;
			end
			for (int i = 0; i < ISSUE_NUM; i++) begin
				if (fwd_hit(ex_src[i], raddr[k])) operand[k] = ex_src[i].wdata;
			end
		end
	end

	assign lane.decoded = dec;
	assign lane.op1     = operand[0];
	assign lane.op2     = operand[1];

endmodule

// ==== hw/issue_ctrl.sv ====
module issue_ctrl #(
	parameter int ISSUE_NUM = 2
) (
	input  logic                                         clk,
	input  logic                                         reset,
	input  logic                                         hold,
	input  issue_pkg::uint32_t   [ISSUE_NUM-1:0]         ex_result,
	decode_lane_if.issue_mp                              lanes [ISSUE_NUM],
	output logic [$clog2(ISSUE_NUM+1)-1:0]               pop_num,
	output issue_pkg::fwd_src_t  [ISSUE_NUM-1:0]         ex_src,
	output logic                                         stall_req,
	output logic                 [ISSUE_NUM-1:0]         issue_valid,
	output issue_pkg::uint32_t   [ISSUE_NUM-1:0]         issue_pc,
	output issue_pkg::op_e       [ISSUE_NUM-1:0]         issue_op,
	output issue_pkg::reg_addr_t [ISSUE_NUM-1:0]         issue_rd,
	output issue_pkg::uint32_t   [ISSUE_NUM-1:0]         issue_imm,
	output issue_pkg::uint32_t   [ISSUE_NUM-1:0]         issue_op1,
	output issue_pkg::uint32_t   [ISSUE_NUM-1:0]         issue_op2,
	output logic [$clog2(ISSUE_NUM+1)-1:0]               issue_num
);

	localparam int CNT_W = $clog2(ISSUE_NUM + 1);

	logic                      [ISSUE_NUM-1:0] pending;
	logic                      [ISSUE_NUM-1:0] load_use;
	issue_pkg::fetch_entry_t   [ISSUE_NUM-1:0] entry;
	issue_pkg::decoded_instr_t [ISSUE_NUM-1:0] dec;
	issue_pkg::uint32_t        [ISSUE_NUM-1:0] op1;
	issue_pkg::uint32_t        [ISSUE_NUM-1:0] op2;
	issue_pkg::decoded_instr_t [ISSUE_NUM-1:0] ex_instr;
	logic [CNT_W-1:0]                          group_cnt;

	function automatic logic reads_reg(issue_pkg::decoded_instr_t d, issue_pkg::reg_addr_t r);
		return (d.uses_rs1 && d.rs1 == r) || (d.uses_rs2 && d.rs2 == r);
	endfunction

	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_lane_in
		assign pending[i] = lanes[i].pending;
		assign entry[i]   = lanes[i].entry;
		assign dec[i]     = lanes[i].decoded;
		assign op1[i]     = lanes[i].op1;
		assign op2[i]     = lanes[i].op2;
	end

	always_comb begin
		for (int i = 0; i < ISSUE_NUM; i++) begin
			load_use[i] = 1'b0;
			for (int j = 0; j < ISSUE_NUM; j++) begin
				if (issue_valid[j] && ex_instr[j].is_load && ex_instr[j].writes_rd &&
				    reads_reg(dec[i], ex_instr[j].rd)) begin
					load_use[i] = 1'b1;
				end
			end
		end
	end

	// longest prefix of the head lanes that may leave together.
	always_comb begin
		logic stop;
		logic blocked;
		logic mem_seen;
		logic branch_seen;
		stop        = 1'b0;
		mem_seen    = 1'b0;
		branch_seen = 1'b0;
		group_cnt   = '0;
		for (int i = 0; i < ISSUE_NUM; i++) begin
			blocked = !pending[i] || load_use[i] || branch_seen || (mem_seen && dec[i].is_mem);
			for (int k = 0; k < i; k++) begin
				if (dec[k].writes_rd && reads_reg(dec[i], dec[k].rd)) blocked = 1'b1;
			end
			if (blocked) stop = 1'b1;
			if (!stop) group_cnt = CNT_W'(i + 1);
			mem_seen    = mem_seen || dec[i].is_mem;
			branch_seen = branch_seen || dec[i].is_branch;
		end
	end

	assign stall_req = pending[0] && load_use[0] && !hold;
	assign pop_num   = hold ? '0 : group_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			issue_valid <= '0;
			issue_num   <= '0;
		end else if (!hold) begin
			for (int i = 0; i < ISSUE_NUM; i++) begin
				issue_valid[i] <= CNT_W'(i) < group_cnt;
			end
			issue_num <= group_cnt;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			ex_instr  <= dec;
			issue_op1 <= op1;
			issue_op2 <= op2;
			for (int i = 0; i < ISSUE_NUM; i++) begin
				issue_pc[i] <= entry[i].pc;
			end
		end
	end

	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_issue_out
		assign issue_op[i]     = ex_instr[i].op;
		assign issue_rd[i]     = ex_instr[i].rd;
		assign issue_imm[i]    = ex_instr[i].imm;
		assign ex_src[i].valid = issue_valid[i] && ex_instr[i].writes_rd && !ex_instr[i].is_load;
		assign ex_src[i].rd    = ex_instr[i].rd;
		assign ex_src[i].wdata = ex_result[i]; // a load in EX has no value yet.
	end

endmodule

// ==== hw/decode_issue_top.sv ====
module decode_issue_top #(
	parameter int ISSUE_NUM   = 2,
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic                                     fetch_push,
	input  issue_pkg::uint32_t   [ISSUE_NUM-1:0]     fetch_pc,
	input  issue_pkg::uint32_t   [ISSUE_NUM-1:0]     fetch_instr,
	output logic                                     queue_full,
	input  issue_pkg::uint32_t   [ISSUE_NUM-1:0]     ex_result,
	input  logic                 [ISSUE_NUM-1:0]     mem_valid,
	input  issue_pkg::reg_addr_t [ISSUE_NUM-1:0]     mem_rd,
	input  issue_pkg::uint32_t   [ISSUE_NUM-1:0]     mem_wdata,
	input  logic                 [ISSUE_NUM-1:0]     wb_valid,
	input  issue_pkg::reg_addr_t [ISSUE_NUM-1:0]     wb_rd,
	input  issue_pkg::uint32_t   [ISSUE_NUM-1:0]     wb_wdata,
	input  logic                                     hold,
	output logic                 [ISSUE_NUM-1:0]     issue_valid,
	output issue_pkg::uint32_t   [ISSUE_NUM-1:0]     issue_pc,
	output issue_pkg::op_e       [ISSUE_NUM-1:0]     issue_op,
	output issue_pkg::reg_addr_t [ISSUE_NUM-1:0]     issue_rd,
	output issue_pkg::uint32_t   [ISSUE_NUM-1:0]     issue_imm,
	output issue_pkg::uint32_t   [ISSUE_NUM-1:0]     issue_op1,
	output issue_pkg::uint32_t   [ISSUE_NUM-1:0]     issue_op2,
	output logic [$clog2(ISSUE_NUM+1)-1:0]           issue_num,
	output logic                                     stall_req
);

	issue_pkg::fetch_entry_t [ISSUE_NUM-1:0]   push_entry;
	issue_pkg::fwd_src_t     [ISSUE_NUM-1:0]   ex_src;
	issue_pkg::fwd_src_t     [ISSUE_NUM-1:0]   mem_src;
	issue_pkg::fwd_src_t     [ISSUE_NUM-1:0]   wb_src;
	issue_pkg::reg_addr_t    [2*ISSUE_NUM-1:0] rf_raddr;
	issue_pkg::uint32_t      [2*ISSUE_NUM-1:0] rf_rdata;
	logic [$clog2(ISSUE_NUM+1)-1:0]            pop_num;

	decode_lane_if lane_bus [ISSUE_NUM] ();

	fetch_queue #(.ISSUE_NUM(ISSUE_NUM), .QUEUE_DEPTH(QUEUE_DEPTH)) u_fetch_queue (
		.clk        (clk),
		.reset      (reset),
		.push       (fetch_push),
		.push_entry (push_entry),
		.pop_num    (pop_num),
		.full       (queue_full),
		.head       (lane_bus)
	);

	reg_file #(.ISSUE_NUM(ISSUE_NUM)) u_reg_file (
		.clk   (clk),
		.reset (reset),
		.raddr (rf_raddr),
		.we    (wb_valid),
		.waddr (wb_rd),
		.wdata (wb_wdata),
		.rdata (rf_rdata)
	);

	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_lane
		assign push_entry[i] = '{pc: fetch_pc[i], instr: fetch_instr[i]};
		assign mem_src[i]    = '{valid: mem_valid[i], rd: mem_rd[i], wdata: mem_wdata[i]};
		assign wb_src[i]     = '{valid: wb_valid[i], rd: wb_rd[i], wdata: wb_wdata[i]};

		decode_lane #(.ISSUE_NUM(ISSUE_NUM)) u_decode_lane (
			.lane    (lane_bus[i]),
			.raddr   (rf_raddr[2*i +: 2]),
			.rdata   (rf_rdata[2*i +: 2]),
			.ex_src  (ex_src),
			.mem_src (mem_src),
			.wb_src  (wb_src)
		);
	end

	issue_ctrl #(.ISSUE_NUM(ISSUE_NUM)) u_issue_ctrl (
		.clk         (clk),
		.reset       (reset),
		.hold        (hold),
		.ex_result   (ex_result),
		.lanes       (lane_bus),
		.pop_num     (pop_num),
		.ex_src      (ex_src),
		.stall_req   (stall_req),
		.issue_valid (issue_valid),
		.issue_pc    (issue_pc),
		.issue_op    (issue_op),
		.issue_rd    (issue_rd),
		.issue_imm   (issue_imm),
		.issue_op1   (issue_op1),
		.issue_op2   (issue_op2),
		.issue_num   (issue_num)
	);

endmodule

// ==== tb/decode_issue_props.sv ====
module decode_issue_props #(
	parameter int ISSUE_NUM = 2
) (
	input logic                                   clk,
	input logic                                   reset,
	input logic                                   hold,
	input logic                                   fetch_push,
	input logic                                   queue_full,
	input logic                 [ISSUE_NUM-1:0]   issue_valid,
	input issue_pkg::uint32_t   [ISSUE_NUM-1:0]   issue_pc,
	input issue_pkg::uint32_t   [ISSUE_NUM-1:0]   issue_op1,
	input issue_pkg::uint32_t   [ISSUE_NUM-1:0]   issue_op2,
	input logic [$clog2(ISSUE_NUM+1)-1:0]         issue_num,
	input logic                                   stall_req
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	a_reset_idle: assert property (@(posedge clk)
		reset |=> (issue_valid == '0 && issue_num == '0 && !queue_full))
		else begin fail_count++; $error("issue outputs or queue_full active after reset"); end

	// valid lanes always form a prefix as long as issue_num.
	a_valid_prefix: assert property (@(posedge clk) disable iff (reset)
		issue_valid == ISSUE_NUM'((1 << issue_num) - 1))
		else begin fail_count++; $error("issue_valid does not match issue_num"); end

	a_stall_bubble: assert property (@(posedge clk) disable iff (reset)
		stall_req |=> issue_valid == '0)
		else begin fail_count++; $error("an instruction issued after stall_req"); end

	a_hold_stable: assert property (@(posedge clk) disable iff (reset)
		hold |=> $stable(issue_valid) && $stable(issue_pc) && $stable(issue_op1) &&
		$stable(issue_op2) && $stable(issue_num))
		else begin fail_count++; $error("issue outputs changed under hold"); end

	// the queue only fills up through a push.
	a_full_after_push: assert property (@(posedge clk) disable iff (reset)
		$rose(queue_full) |-> $past(fetch_push))
		else begin fail_count++; $error("queue_full rose without a push"); end

endmodule

// ==== tb/tb_decode_issue.sv ====
module tb_decode_issue;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ISSUE_NUM   = 2;
	localparam int QUEUE_DEPTH = 8;
	localparam int CLK_PERIOD  = 20;
	localparam int PHASES      = 7;
	localparam int RAND_PUSHES = 200;
	localparam logic [11:0] TEST_IMM = 12'h014;
	localparam issue_pkg::uint32_t TEST_IMM_EXT = {{20{TEST_IMM[11]}}, TEST_IMM};

	logic clk;
	logic reset;
	logic fetch_push;
	logic hold;
	logic queue_full;
	logic stall_req;
	logic [1:0] issue_num;
	logic [1:0] mem_valid;
	logic [1:0] wb_valid;
	logic [1:0] issue_valid;
	issue_pkg::reg_addr_t [1:0] mem_rd;
	issue_pkg::reg_addr_t [1:0] wb_rd;
	issue_pkg::reg_addr_t [1:0] issue_rd;
	issue_pkg::uint32_t [1:0] fetch_pc;
	issue_pkg::uint32_t [1:0] fetch_instr;
	issue_pkg::uint32_t [1:0] ex_result;
	issue_pkg::uint32_t [1:0] mem_wdata;
	issue_pkg::uint32_t [1:0] wb_wdata;
	issue_pkg::uint32_t [1:0] issue_pc;
	issue_pkg::uint32_t [1:0] issue_imm;
	issue_pkg::uint32_t [1:0] issue_op1;
	issue_pkg::uint32_t [1:0] issue_op2;
	issue_pkg::op_e [1:0] issue_op;

	issue_pkg::uint32_t shadow [32];
	issue_pkg::uint32_t q_pc [$];
	issue_pkg::uint32_t q_ins [$];
	issue_pkg::op_e q_op [$];
	issue_pkg::op_e push_op [2];
	issue_pkg::uint32_t snap_op1 [2];
	issue_pkg::uint32_t snap_op2 [2];
	issue_pkg::uint32_t next_pc;
	int snap_cnt;
	int err_count;
	int seed;
	logic prev_hold;
	logic rand_pipe;
	logic stall_seen;
	logic full_seen;
	string test_name;

	decode_issue_top #(.ISSUE_NUM(ISSUE_NUM), .QUEUE_DEPTH(QUEUE_DEPTH)) u_dut (.*);

	bind decode_issue_top decode_issue_props #(.ISSUE_NUM(ISSUE_NUM)) u_props (
		.clk(clk), .reset(reset), .hold(hold), .fetch_push(fetch_push),
		.queue_full(queue_full), .issue_valid(issue_valid), .issue_pc(issue_pc),
		.issue_op1(issue_op1), .issue_op2(issue_op2), .issue_num(issue_num),
		.stall_req(stall_req)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// RV32I field layouts of the supported subset.
	function automatic issue_pkg::uint32_t encode(issue_pkg::op_e op, logic [4:0] rd,
	                                              logic [4:0] rs1, logic [4:0] rs2);
		logic [11:0] imm;
		imm = TEST_IMM;
		case (op)
			issue_pkg::OP_ADD:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
			issue_pkg::OP_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
			issue_pkg::OP_AND:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
			issue_pkg::OP_OR:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
			issue_pkg::OP_XOR:  return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
			issue_pkg::OP_SLT:  return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
			issue_pkg::OP_ADDI: return {imm, rs1, 3'b000, rd, 7'b0010011};
			issue_pkg::OP_LW:   return {imm, rs1, 3'b010, rd, 7'b0000011};
			issue_pkg::OP_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
			issue_pkg::OP_BEQ:  return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b1100011};
			default:            return 32'h0;
		endcase
	endfunction

	function automatic logic writes_reg(issue_pkg::op_e op, logic [4:0] rd);
		return rd != 0 && !(op inside {issue_pkg::OP_SW, issue_pkg::OP_BEQ});
	endfunction

	function automatic logic reads_reg(issue_pkg::op_e op, issue_pkg::uint32_t ins, logic [4:0] r);
		logic rs2_used;
		rs2_used = !(op inside {issue_pkg::OP_ADDI, issue_pkg::OP_LW});
		return r != 0 && (ins[19:15] == r || (rs2_used && ins[24:20] == r));
	endfunction

	// the newest value of a register comes from EX, then MEM, then WB, then the register file.
	function automatic issue_pkg::uint32_t predict(logic [4:0] r);
		issue_pkg::uint32_t v;
		v = shadow[r];
		for (int i = 0; i < 2; i++) if (wb_valid[i] && wb_rd[i] == r) v = wb_wdata[i];
		for (int i = 0; i < 2; i++) if (mem_valid[i] && mem_rd[i] == r) v = mem_wdata[i];
		for (int i = 0; i < 2; i++) begin
			if (issue_valid[i] && writes_reg(issue_op[i], issue_rd[i]) &&
			    issue_op[i] != issue_pkg::OP_LW && issue_rd[i] == r) v = ex_result[i];
		end
		return (r == 0) ? 32'h0 : v;
	endfunction

	task automatic report_mismatch(string what, issue_pkg::uint32_t exp, issue_pkg::uint32_t act);
		$display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
		err_count++;
	endtask

	always @(negedge clk) begin : monitor
		logic stop;
		logic mem_seen;
		logic br_seen;
		logic lu;
		logic blocked;
		if (reset) begin
			prev_hold = 1'b1;
		end else begin
			if (!prev_hold) begin
				if (issue_num != snap_cnt) report_mismatch("issue_num", snap_cnt, issue_num);
				for (int i = 0; i < issue_num; i++) begin
					if (q_pc.size() == 0) begin
						$display("ERROR %s: an instruction issued that was never pushed", test_name);
						err_count++;
					end else begin
						if (issue_pc[i] != q_pc[0])
							report_mismatch("issue_pc", q_pc[0], issue_pc[i]);
						if (issue_op[i] != q_op[0])
							report_mismatch("issue_op", q_op[0], issue_op[i]);
						if (!(q_op[0] inside {issue_pkg::OP_SW, issue_pkg::OP_BEQ}) &&
						    issue_rd[i] != q_ins[0][11:7])
							report_mismatch("issue_rd", q_ins[0][11:7], issue_rd[i]);
						if (q_op[0] inside {issue_pkg::OP_ADDI, issue_pkg::OP_LW,
						                    issue_pkg::OP_SW, issue_pkg::OP_BEQ} &&
						    issue_imm[i] != TEST_IMM_EXT)
							report_mismatch("issue_imm", TEST_IMM_EXT, issue_imm[i]);
						if (issue_op1[i] != snap_op1[i])
							report_mismatch("issue_op1", snap_op1[i], issue_op1[i]);
						if (issue_op2[i] != snap_op2[i])
							report_mismatch("issue_op2", snap_op2[i], issue_op2[i]);
						void'(q_pc.pop_front());
						void'(q_ins.pop_front());
						void'(q_op.pop_front());
					end
				end
			end
			if (queue_full != (q_pc.size() > QUEUE_DEPTH - ISSUE_NUM))
				report_mismatch("queue_full", q_pc.size() > QUEUE_DEPTH - ISSUE_NUM, queue_full);
			stop = 1'b0;
			mem_seen = 1'b0;
			br_seen = 1'b0;
			snap_cnt = 0;
			for (int i = 0; i < 2; i++) begin
				lu = 1'b0;
				blocked = i >= q_pc.size();
				if (!blocked) begin
					snap_op1[i] = predict(q_ins[i][19:15]);
					snap_op2[i] = predict(q_ins[i][24:20]);
					for (int j = 0; j < 2; j++) begin
						if (issue_valid[j] && issue_op[j] == issue_pkg::OP_LW &&
						    reads_reg(q_op[i], q_ins[i], issue_rd[j])) lu = 1'b1;
					end
					if (i == 1 && writes_reg(q_op[0], q_ins[0][11:7]) &&
					    reads_reg(q_op[1], q_ins[1], q_ins[0][11:7])) blocked = 1'b1;
					blocked = blocked || lu || br_seen ||
					          (mem_seen && q_op[i] inside {issue_pkg::OP_LW, issue_pkg::OP_SW});
					if (i == 0 && stall_req != (lu && !hold))
						report_mismatch("stall_req", lu && !hold, stall_req);
					mem_seen = q_op[i] inside {issue_pkg::OP_LW, issue_pkg::OP_SW};
					br_seen = q_op[i] == issue_pkg::OP_BEQ;
				end else if (i == 0 && stall_req) begin
					report_mismatch("stall_req", 0, stall_req);
				end
				if (blocked) stop = 1'b1;
				if (!stop) snap_cnt = i + 1;
			end
			if (stall_req) stall_seen = 1'b1;
			if (queue_full) full_seen = 1'b1;
			prev_hold = hold;
			if (fetch_push && !queue_full) begin
				for (int i = 0; i < 2; i++) begin
					q_pc.push_back(fetch_pc[i]);
					q_ins.push_back(fetch_instr[i]);
					q_op.push_back(push_op[i]);
				end
			end
			for (int i = 0; i < 2; i++) begin
				if (wb_valid[i] && wb_rd[i] != 0) shadow[wb_rd[i]] = wb_wdata[i];
			end
		end
	end

	task automatic step();
		@(posedge clk);
		#2;
		fetch_push = 1'b0;
		ex_result = {$random(seed), $random(seed)};
		mem_valid = '0;
		wb_valid = '0;
		if (rand_pipe) begin
			mem_valid = 2'($random(seed));
			wb_valid = 2'($random(seed));
			mem_rd = {5'($random(seed) & 7), 5'($random(seed) & 7)};
			wb_rd = {5'($random(seed) & 7), 5'($random(seed) & 7)};
			mem_wdata = {$random(seed), $random(seed)};
			wb_wdata = {$random(seed), $random(seed)};
			hold = ($random(seed) & 7) == 0;
		end
	endtask

	task automatic push_pair(issue_pkg::op_e o0, logic [4:0] d0, logic [4:0] a0, logic [4:0] b0,
	                         issue_pkg::op_e o1, logic [4:0] d1, logic [4:0] a1, logic [4:0] b1);
		step();
		while (queue_full) step();
		fetch_push = 1'b1;
		fetch_pc = {next_pc + 32'd4, next_pc};
		fetch_instr = {encode(o1, d1, a1, b1), encode(o0, d0, a0, b0)};
		push_op[0] = o0;
		push_op[1] = o1;
		next_pc += 32'd8;
	endtask

	task automatic drain();
		step();
		while (q_pc.size() != 0 || hold) step();
		repeat (2) step();
	endtask

	initial begin : watchdog
		#((PHASES * 50 + RAND_PUSHES * 4) * CLK_PERIOD);
		$display("timeout: the run did not complete in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		issue_pkg::op_e ra;
		issue_pkg::op_e rb;
		seed = 56;
		err_count = 0;
		next_pc = 32'h1000;
		{clk, fetch_push, hold, rand_pipe, stall_seen, full_seen} = '0;
		{fetch_pc, fetch_instr, ex_result, mem_wdata, wb_wdata} = '0;
		{mem_valid, wb_valid, mem_rd, wb_rd} = '0;
		foreach (shadow[r]) shadow[r] = '0;
		test_name = "reset";
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#2 reset = 1'b0;
		repeat (5) step();

		test_name = "preload";
		for (int r = 1; r < 15; r += 2) begin
			step();
			wb_valid = 2'b11;
			wb_rd = {5'(r + 1), 5'(r)};
			wb_wdata = {$random(seed), $random(seed)};
		end

		test_name = "alu_pair";
		push_pair(issue_pkg::OP_ADD, 10, 1, 2, issue_pkg::OP_SUB, 11, 3, 4);
		drain();

		test_name = "forwarding";
		rand_pipe = 1'b1;
		push_pair(issue_pkg::OP_ADD, 3, 1, 2, issue_pkg::OP_OR, 4, 5, 6);
		push_pair(issue_pkg::OP_XOR, 7, 3, 4, issue_pkg::OP_SLT, 9, 1, 5);
		push_pair(issue_pkg::OP_AND, 2, 6, 7, issue_pkg::OP_ADDI, 8, 3, 0);
		rand_pipe = 1'b0;
		hold = 1'b0;
		drain();

		test_name = "group_rules";
		push_pair(issue_pkg::OP_ADD, 5, 1, 2, issue_pkg::OP_ADD, 6, 5, 1);
		push_pair(issue_pkg::OP_LW, 7, 1, 0, issue_pkg::OP_SW, 0, 1, 2);
		push_pair(issue_pkg::OP_BEQ, 0, 1, 2, issue_pkg::OP_ADD, 8, 3, 4);
		drain();
		test_name = "load_use";
		push_pair(issue_pkg::OP_LW, 5, 1, 0, issue_pkg::OP_ADD, 6, 2, 3);
		push_pair(issue_pkg::OP_ADD, 7, 5, 1, issue_pkg::OP_XOR, 9, 2, 3);
		drain();
		if (!stall_seen) begin
			$display("ERROR %s: stall_req never rose for a lane-0 load consumer", test_name);
			err_count++;
		end

		test_name = "hold_full";
		step();
		hold = 1'b1;
		repeat (4) push_pair(issue_pkg::OP_ADDI, 12, 1, 0, issue_pkg::OP_OR, 13, 2, 3);
		repeat (2) step();
		if (!full_seen) begin
			$display("ERROR %s: queue_full did not rise with the queue filled", test_name);
			err_count++;
		end
		hold = 1'b0;
		drain();

		test_name = "random";
		rand_pipe = 1'b1;
		for (int n = 0; n < RAND_PUSHES; n++) begin
			ra = issue_pkg::op_e'($unsigned($random(seed)) % 10);
			rb = issue_pkg::op_e'($unsigned($random(seed)) % 10);
			push_pair(ra, 5'($random(seed) & 7), 5'($random(seed) & 7), 5'($random(seed) & 7),
			          rb, 5'($random(seed) & 7), 5'($random(seed) & 7), 5'($random(seed) & 7));
		end
		rand_pipe = 1'b0;
		hold = 1'b0;
		drain();

		$display("errors: %0d, assertion failures: %0d", err_count, u_dut.u_props.fail_count);
		if (err_count == 0 && u_dut.u_props.fail_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== project.f ====
hw/issue_pkg.sv
hw/decode_lane_if.sv
hw/fetch_queue.sv
hw/reg_file.sv
hw/decode_lane.sv
hw/issue_ctrl.sv
hw/decode_issue_top.sv
tb/decode_issue_props.sv
tb/tb_decode_issue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_decode_issue
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
